// File: hw/mem_pkg.sv
package mem_pkg;

    // datapath and address width
    localparam int XLEN    = 64;
    // rob id: top bit is the wrap flag, low bits the index
    localparam int ROBID_W = 7;
    localparam int PREG_W  = 6;

    typedef enum logic [1:0] {
        LS_BYTE  = 2'd0,
        LS_HALF  = 2'd1,
        LS_WORD  = 2'd2,
        LS_DWORD = 2'd3
    } ls_size_e;

    typedef enum logic {
        TBUS_READ  = 1'b0,
        TBUS_WRITE = 1'b1
    } tbus_op_e;

    typedef struct packed {
        logic [ROBID_W-1:0] robid;
        logic [PREG_W-1:0]  prd;
        logic [XLEN-1:0]    base;
        logic [XLEN-1:0]    sdata;
        logic [XLEN-1:0]    imm;
        logic               is_load;
        logic               is_store;
        logic               is_unsigned;
        ls_size_e           size;
    } mem_issue_t;

    typedef struct packed {
        logic [ROBID_W-1:0] robid;
        logic [PREG_W-1:0]  prd;
        logic               need_wb;
        logic               mmio;
        logic [XLEN-1:0]    load_data;
    } mem_wb_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [7:0]      wmask;
        tbus_op_e        op;
    } tbus_req_t;

    // true when id a is older than id b
    function automatic logic rob_older(input logic [ROBID_W-1:0] a,
                                       input logic [ROBID_W-1:0] b);
        logic same_wrap;
        logic idx_less;
        same_wrap = (a[ROBID_W-1] == b[ROBID_W-1]);
        idx_less  = (a[ROBID_W-2:0] < b[ROBID_W-2:0]);
        // once the wrap flags differ the index order flips
        return same_wrap ? idx_less : !idx_less && (a[ROBID_W-2:0] != b[ROBID_W-2:0]);
    endfunction

endpackage

// File: hw/store_align.sv
`timescale 1ns/1ps

module store_align import mem_pkg::*; (
    input  ls_size_e        size,
    input  logic [2:0]      offset,
    input  logic [XLEN-1:0] data,
    output logic [XLEN-1:0] wdata,
    output logic [7:0]      wmask
);

    logic [7:0]  base_mask;
    // wide copy so that a mask running off the doubleword stays visible
    logic [15:0] wide_mask;

    always_comb begin
        case (size)
            LS_BYTE:  base_mask = 8'h01;
            LS_HALF:  base_mask = 8'h03;
            LS_WORD:  base_mask = 8'h0f;
            default:  base_mask = 8'hff;
        endcase
    end

    assign wide_mask = {8'h00, base_mask} << offset;
    assign wmask     = wide_mask[7:0];

    // byte lanes move up by the address offset
    assign wdata = data << {offset, 3'b000};

    // an aligned access never spills past byte 7
    always_comb begin
        assert final (wide_mask[15:8] == 8'h00 || $isunknown(wide_mask))
        else $error("store mask runs past byte 7: size %0d offset %0d", size, offset);
    end

endmodule

// File: hw/load_extract.sv
`timescale 1ns/1ps

module load_extract import mem_pkg::*; (
    input  ls_size_e        size,
    input  logic [2:0]      offset,
    input  logic            is_unsigned,
    input  logic [XLEN-1:0] rdata,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] shifted;
    logic            fill_b;
    logic            fill_h;
    logic            fill_w;

    // bring the addressed bytes down to lane 0
    assign shifted = rdata >> {offset, 3'b000};

    // sign bit of the top kept byte, or zero for unsigned loads
    assign fill_b = !is_unsigned && shifted[7];
    assign fill_h = !is_unsigned && shifted[15];
    assign fill_w = !is_unsigned && shifted[31];

    always_comb begin
        case (size)
            LS_BYTE: begin
                result = {{56{fill_b}}, shifted[7:0]};
            end
            LS_HALF: begin
                result = {{48{fill_h}}, shifted[15:0]};
            end
            LS_WORD: begin
                result = {{32{fill_w}}, shifted[31:0]};
            end
            default: begin
                // full doubleword, nothing to extend
                result = rdata;
            end
        endcase
    end

endmodule

// File: hw/memblock.sv
`timescale 1ns/1ps

module memblock import mem_pkg::*; #(
    parameter logic [XLEN-1:0] MMIO_BASE  = 64'h0000_0000_3000_0000,
    parameter logic [XLEN-1:0] MMIO_LIMIT = 64'h0000_0000_4070_0000
) (
    input  logic               clock,
    input  logic               reset_n,

    // issue channel
    input  logic               issue_valid,
    output logic               issue_ready,
    input  mem_issue_t         issue,

    // request bus toward the data memory
    output logic               tbus_valid,
    input  logic               tbus_ready,
    output tbus_req_t          tbus_req,
    input  logic               tbus_done,
    input  logic [XLEN-1:0]    tbus_rdata,

    // writeback record
    output logic               wb_valid,
    output mem_wb_t            wb,

    // redirect
    input  logic               flush_valid,
    input  logic [ROBID_W-1:0] flush_robid,
    output logic               dcache_flush
);

    typedef enum logic [1:0] {
        ST_IDLE        = 2'd0,
        ST_PENDING     = 2'd1,
        ST_OUTSTANDING = 2'd2
    } ls_state_e;

    ls_state_e       state;
    mem_issue_t      op_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] issue_addr;
    logic            issue_mmio;
    logic            accept;
    logic            mmio_pend;
    logic            kill_q;
    logic            in_flight;
    logic            bus_done;
    logic            op_done;
    logic [XLEN-1:0] st_wdata;
    logic [7:0]      st_wmask;
    logic [XLEN-1:0] ld_result;

    assign accept = issue_valid && issue_ready;

    // effective address and window check on the incoming operation
    assign issue_addr = issue.base + issue.imm;
    assign issue_mmio = (issue_addr >= MMIO_BASE) && (issue_addr <= MMIO_LIMIT);

    // operation payload, only meaningful while busy
    always_ff @(posedge clock) begin
        if (accept) begin
            op_q   <= issue;
            addr_q <= issue_addr;
        end
    end

    // mmio ops complete on the cycle right after acceptance
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mmio_pend <= 1'b0;
        end else begin
            mmio_pend <= accept && issue_mmio;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept && !issue_mmio) begin
                        state <= ST_PENDING;
                    end
                end
                ST_PENDING: begin
                    if (tbus_ready) begin
                        state <= ST_OUTSTANDING;
                    end
                end
                ST_OUTSTANDING: begin
                    if (tbus_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign bus_done = (state == ST_OUTSTANDING) && tbus_done;
    assign op_done  = bus_done || mmio_pend;

    // one operation at a time; ready returns once the op has completed
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            issue_ready <= 1'b1;
        end else if (accept) begin
            issue_ready <= 1'b0;
        end else if (op_done) begin
            issue_ready <= 1'b1;
        end
    end

    // redirect older than the op in flight squashes its writeback
    assign in_flight    = (state != ST_IDLE) || mmio_pend;
    assign dcache_flush = flush_valid && in_flight && rob_older(flush_robid, op_q.robid);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            kill_q <= 1'b0;
        end else if (accept) begin
            kill_q <= 1'b0;
        end else if (dcache_flush) begin
            kill_q <= 1'b1;
        end
    end

    store_align store_align_i (
        .size   (op_q.size),
        .offset (addr_q[2:0]),
        .data   (op_q.sdata),
        .wdata  (st_wdata),
        .wmask  (st_wmask)
    );

    load_extract load_extract_i (
        .size        (op_q.size),
        .offset      (addr_q[2:0]),
        .is_unsigned (op_q.is_unsigned),
        .rdata       (tbus_rdata),
        .result      (ld_result)
    );

    // request is built from latched state so it holds while pending
    assign tbus_valid     = (state == ST_PENDING);
    assign tbus_req.addr  = addr_q;
    assign tbus_req.wdata = st_wdata;
    assign tbus_req.wmask = st_wmask;
    assign tbus_req.op    = op_q.is_store ? TBUS_WRITE : TBUS_READ;

    assign wb_valid = op_done && !kill_q && !dcache_flush;

    assign wb.robid     = op_q.robid;
    assign wb.prd       = op_q.prd;
    assign wb.need_wb   = op_q.is_load;
    assign wb.mmio      = mmio_pend;
    // mmio bypasses memory and returns zero
    assign wb.load_data = (op_q.is_load && !mmio_pend) ? ld_result : '0;

    a_req_stable: assert property (
        @(posedge clock) disable iff (!reset_n)
        tbus_valid && !tbus_ready |=> tbus_valid && $stable(tbus_req)
    ) else $error("bus request changed before it fired");

    a_done_outstanding: assert property (
        @(posedge clock) disable iff (!reset_n)
        tbus_done |-> state == ST_OUTSTANDING
    ) else $error("done pulse with no request outstanding");

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps

module data_ram import mem_pkg::*; #(
    parameter int RAM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            stall,
    input  logic            tbus_valid,
    output logic            tbus_ready,
    input  tbus_req_t       tbus_req,
    output logic            tbus_done,
    output logic [XLEN-1:0] tbus_rdata
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [XLEN-1:0]         mem [RAM_WORDS];
    logic [XLEN-1:0]         word_addr;
    logic [IDX_W-1:0]        idx;
    logic                    fire;
    logic [READ_LATENCY-1:0] done_sr;
    logic [XLEN-1:0]         data_sr [READ_LATENCY];

    assign tbus_ready = !stall;
    assign fire       = tbus_valid && tbus_ready;

    // doubleword index wraps around the array size
    assign word_addr = tbus_req.addr >> 3;
    assign idx       = IDX_W'(word_addr % XLEN'(RAM_WORDS));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (fire && tbus_req.op == TBUS_WRITE) begin
            for (int b = 0; b < 8; b++) begin
                if (tbus_req.wmask[b]) begin
                    mem[idx][8*b +: 8] <= tbus_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // latency pipe, done for every fired request
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            done_sr <= '0;
        end else begin
            done_sr[0] <= fire;
            for (int i = 1; i < READ_LATENCY; i++) begin
                done_sr[i] <= done_sr[i-1];
            end
        end
    end

    // read data captured at the fire, before any write lands
    always_ff @(posedge clock) begin
        data_sr[0] <= mem[idx];
        for (int i = 1; i < READ_LATENCY; i++) begin
            data_sr[i] <= data_sr[i-1];
        end
    end

    assign tbus_done  = done_sr[READ_LATENCY-1];
    assign tbus_rdata = data_sr[READ_LATENCY-1];

    a_write_mask: assert property (
        @(posedge clock) disable iff (!reset_n)
        fire && tbus_req.op == TBUS_WRITE |-> tbus_req.wmask != 8'h00
    ) else $error("write fired with an empty byte mask");

endmodule

// File: hw/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys import mem_pkg::*; #(
    parameter logic [XLEN-1:0] MMIO_BASE    = 64'h0000_0000_3000_0000,
    parameter logic [XLEN-1:0] MMIO_LIMIT   = 64'h0000_0000_4070_0000,
    parameter int              RAM_WORDS    = 256,
    parameter int              READ_LATENCY = 2
) (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               issue_valid,
    output logic               issue_ready,
    input  mem_issue_t         issue,
    output logic               wb_valid,
    output mem_wb_t            wb,
    input  logic               flush_valid,
    input  logic [ROBID_W-1:0] flush_robid,
    output logic               dcache_flush,
    input  logic               mem_stall
);

    logic            tbus_valid;
    logic            tbus_ready;
    tbus_req_t       tbus_req;
    logic            tbus_done;
    logic [XLEN-1:0] tbus_rdata;

    memblock #(
        .MMIO_BASE  (MMIO_BASE),
        .MMIO_LIMIT (MMIO_LIMIT)
    ) memblock_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .tbus_valid   (tbus_valid),
        .tbus_ready   (tbus_ready),
        .tbus_req     (tbus_req),
        .tbus_done    (tbus_done),
        .tbus_rdata   (tbus_rdata),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .flush_valid  (flush_valid),
        .flush_robid  (flush_robid),
        .dcache_flush (dcache_flush)
    );

    // stands in for the data cache
    data_ram #(
        .RAM_WORDS    (RAM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) data_ram_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .stall      (mem_stall),
        .tbus_valid (tbus_valid),
        .tbus_ready (tbus_ready),
        .tbus_req   (tbus_req),
        .tbus_done  (tbus_done),
        .tbus_rdata (tbus_rdata)
    );

endmodule

// File: dv/tb_mem_tasks.svh
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

    task automatic check_wb(input mem_wb_t exp, input mem_wb_t got);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s: wb expected %h actual %h", current_test, exp, got));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic got);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s: %s expected %b actual %b",
                               current_test, what, exp, got));
        end
    endtask

    // immediate is random, base is chosen so that base + imm lands on addr
    function automatic mem_issue_t make_op(input logic [XLEN-1:0] addr,
                                           input logic [XLEN-1:0] data, input logic is_load,
                                           input logic is_unsigned, input ls_size_e size);
        mem_issue_t  op;
        logic [11:0] imm12;
        imm12          = 12'($random(seed));
        op.robid       = next_rob;
        op.prd         = PREG_W'($random(seed));
        op.imm         = {{(XLEN-12){imm12[11]}}, imm12};
        op.base        = addr - op.imm;
        op.sdata       = data;
        op.is_load     = is_load;
        op.is_store    = !is_load;
        op.is_unsigned = is_unsigned;
        op.size        = size;
        next_rob       = next_rob + 7'd1;
        return op;
    endfunction

    // issue one op, wait for its writeback and check it against the model
    task automatic run_op(input mem_issue_t op, input logic stall_on, output int lat);
        logic [XLEN-1:0] addr;
        logic            mmio;
        mem_wb_t         exp;
        addr          = op.base + op.imm;
        mmio          = (addr >= MMIO_LO) && (addr <= MMIO_HI);
        exp.robid     = op.robid;
        exp.prd       = op.prd;
        exp.need_wb   = op.is_load;
        exp.mmio      = mmio;
        exp.load_data = (op.is_load && !mmio) ? ref_load(addr, op.size, op.is_unsigned) : '0;
        @(posedge clock);
        issue_valid <= 1'b1;
        issue       <= op;
        @(negedge clock);
        while (!issue_ready) begin
            @(negedge clock);
        end
        // this edge accepts the op
        @(posedge clock);
        issue_valid <= 1'b0;
        lat = 0;
        do begin
            if (stall_on) begin
                mem_stall <= (($random(seed) & 3) != 0);
            end
            @(negedge clock);
            lat++;
            check_bit("issue_ready while busy", 1'b0, issue_ready);
            if (!wb_valid) begin
                @(posedge clock);
            end
        end while (!wb_valid);
        check_wb(exp, wb);
        if (op.is_store && !mmio) begin
            ref_store(addr, op.size, op.sdata);
        end
        @(posedge clock);
        mem_stall <= 1'b0;
        @(negedge clock);
        check_bit("second writeback", 1'b0, wb_valid);
        check_bit("issue_ready after writeback", 1'b1, issue_ready);
    endtask

    task automatic dword_roundtrip();
        int lat;
        current_test = "dword_roundtrip";
        for (int i = 0; i < 6; i++) begin
            run_op(make_op(64'h200 + 64'(24 * i), {$random(seed), $random(seed)},
                           1'b0, 1'b0, LS_DWORD), 1'b0, lat);
        end
        for (int i = 0; i < 6; i++) begin
            run_op(make_op(64'h200 + 64'(24 * i), '0, 1'b1, 1'b0, LS_DWORD), 1'b0, lat);
        end
    endtask

    task automatic subword_access();
        ls_size_e        sz;
        int              nb;
        int              lat;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] sd;
        current_test = "subword_access";
        for (int s = 0; s < 3; s++) begin
            sz = ls_size_e'(s);
            nb = 1 << s;
            for (int off = 0; off < 8; off += nb) begin
                addr = 64'h400 + 64'(off);
                sd   = {$random(seed), $random(seed)};
                // every other slot gets its top kept bit set for sign fill
                sd[8*nb-1] = ((off / nb) % 2 == 0);
                run_op(make_op(addr, sd, 1'b0, 1'b0, sz), 1'b0, lat);
                run_op(make_op(addr, '0, 1'b1, 1'b0, sz), 1'b0, lat);
                run_op(make_op(addr, '0, 1'b1, 1'b1, sz), 1'b0, lat);
            end
        end
    endtask

    task automatic stall_backpressure();
        int              lat;
        logic [XLEN-1:0] addr;
        current_test = "stall_backpressure";
        for (int i = 0; i < 4; i++) begin
            addr = 64'h600 + 64'(8 * i);
            run_op(make_op(addr, {$random(seed), $random(seed)}, 1'b0, 1'b0, LS_DWORD),
                   1'b1, lat);
            run_op(make_op(addr + 64'h2, 16'($random(seed)), 1'b0, 1'b0, LS_HALF), 1'b1, lat);
            run_op(make_op(addr + 64'h4, '0, 1'b1, 1'b0, LS_WORD), 1'b1, lat);
            run_op(make_op(addr, '0, 1'b1, 1'b0, LS_DWORD), 1'b1, lat);
        end
    endtask

    task automatic mmio_window();
        int lat;
        current_test = "mmio_window";
        run_op(make_op(64'h100, {$random(seed), $random(seed)}, 1'b0, 1'b0, LS_DWORD),
               1'b0, lat);
        // this window address aliases ram byte 0x100 if it ever reached the bus
        run_op(make_op(MMIO_LO + 64'h100, 64'hdead_beef_0bad_f00d, 1'b0, 1'b0, LS_DWORD),
               1'b0, lat);
        check_bit("mmio store done one cycle after accept", 1'b1, lat == 1);
        run_op(make_op(MMIO_HI, '0, 1'b1, 1'b0, LS_WORD), 1'b0, lat);
        check_bit("mmio load done one cycle after accept", 1'b1, lat == 1);
        run_op(make_op(64'h100, '0, 1'b1, 1'b0, LS_DWORD), 1'b0, lat);
    endtask

    // load held pending under stall while a redirect with fl_rob arrives
    task automatic flush_case(input logic [ROBID_W-1:0] op_rob,
                              input logic [ROBID_W-1:0] fl_rob, input logic expect_kill);
        mem_issue_t op;
        mem_wb_t    exp;
        logic       seen;
        op            = make_op(64'h200, '0, 1'b1, 1'b0, LS_DWORD);
        op.robid      = op_rob;
        exp.robid     = op_rob;
        exp.prd       = op.prd;
        exp.need_wb   = 1'b1;
        exp.mmio      = 1'b0;
        exp.load_data = ref_load(64'h200, LS_DWORD, 1'b0);
        seen          = 1'b0;
        @(posedge clock);
        mem_stall   <= 1'b1;
        issue_valid <= 1'b1;
        issue       <= op;
        @(negedge clock);
        while (!issue_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        issue_valid <= 1'b0;
        @(posedge clock);
        flush_valid <= 1'b1;
        flush_robid <= fl_rob;
        @(negedge clock);
        check_bit("dcache_flush", expect_kill, dcache_flush);
        @(posedge clock);
        flush_valid <= 1'b0;
        mem_stall   <= 1'b0;
        do begin
            @(negedge clock);
            if (wb_valid) begin
                seen = 1'b1;
                check_wb(exp, wb);
            end
        end while (!issue_ready);
        check_bit("writeback after redirect", !expect_kill, seen);
    endtask

    task automatic flush_by_age();
        current_test = "flush_by_age";
        // same wrap flag, the lower index is older
        flush_case(7'h15, 7'h05, 1'b1);
        // wrap flags differ so the higher index is older
        flush_case(7'h02, 7'h45, 1'b1);
        flush_case(7'h10, 7'h20, 1'b0);
        flush_case(7'h10, 7'h41, 1'b0);
    endtask

`endif

// File: dv/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys
    import mem_pkg::*;
();

    localparam logic [XLEN-1:0] MMIO_LO = 64'h0000_0000_3000_0000;
    localparam logic [XLEN-1:0] MMIO_HI = 64'h0000_0000_4070_0000;
    localparam int NUM_TESTS = 5;
    // per-test budget, well above the longest test of about 45 operations
    localparam int TEST_BUDGET_NS = 20000;

    logic               clock;
    logic               reset_n;
    logic               issue_valid;
    logic               issue_ready;
    mem_issue_t         issue;
    logic               wb_valid;
    mem_wb_t            wb;
    logic               flush_valid;
    logic [ROBID_W-1:0] flush_robid;
    logic               dcache_flush;
    logic               mem_stall;

    int                 seed;
    logic [ROBID_W-1:0] next_rob;
    string              current_test;
    // byte image of the low 2 KiB of data memory
    logic [7:0]         ref_mem [2048];

    mem_subsys mem_subsys_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .flush_valid  (flush_valid),
        .flush_robid  (flush_robid),
        .dcache_flush (dcache_flush),
        .mem_stall    (mem_stall)
    );

    always #10 clock = ~clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic void ref_store(input logic [XLEN-1:0] addr, input ls_size_e size,
                                      input logic [XLEN-1:0] data);
        int base;
        int nbytes;
        base   = int'(addr[10:0]);
        nbytes = 1 << int'(size);
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[base + i] = data[8*i +: 8];
        end
    endfunction

    // gather the bytes low to high, then sign or zero fill above them
    function automatic logic [XLEN-1:0] ref_load(input logic [XLEN-1:0] addr,
                                                 input ls_size_e size, input logic is_unsigned);
        int              base;
        int              nbytes;
        logic [XLEN-1:0] val;
        base   = int'(addr[10:0]);
        nbytes = 1 << int'(size);
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = ref_mem[base + i];
        end
        if (!is_unsigned && val[8*nbytes-1]) begin
            for (int i = 8 * nbytes; i < XLEN; i++) begin
                val[i] = 1'b1;
            end
        end
        return val;
    endfunction

    `include "tb_mem_tasks.svh"

    initial begin
        #(NUM_TESTS * TEST_BUDGET_NS);
        fail_run($sformatf("timeout: test %s did not finish within %0d ns",
                           current_test, NUM_TESTS * TEST_BUDGET_NS));
    end

    initial begin
        clock        = 1'b0;
        reset_n      = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        flush_valid  = 1'b0;
        flush_robid  = '0;
        mem_stall    = 1'b0;
        seed         = 32'h8046;
        next_rob     = '0;
        current_test = "reset";
        for (int i = 0; i < 2048; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (4) @(posedge clock);
        reset_n <= 1'b1;
        dword_roundtrip();
        subword_access();
        stall_backpressure();
        mmio_window();
        flush_by_age();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+dv
hw/mem_pkg.sv
hw/store_align.sv
hw/load_extract.sv
hw/memblock.sv
hw/data_ram.sv
hw/mem_subsys.sv
dv/tb_mem_subsys.sv

// File: Makefile
# Verilator build and run for the memory execution block

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := dv/tb_mem_tasks.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
